/* build.f */
+incdir+sim
common/mem_sys_pkg.sv
cache/cache_way.sv
memory/four_bank_mem.sv
cache/cache_ctrl.sv
source/mem_system.sv
sim/mem_system_tb.sv

/* cache/cache_ctrl.sv */
// Cache controller FSM: compare, write-back, refill, completion
// Accepts a request only in st_idle, stall is high in every other state
// Memory accesses are scheduled by cycle count, one bank per cycle in turn
// Misaligned address or rd with wr ends in st_err_done without touching the cache

`timescale 1ns/1ps

module cache_ctrl
   import mem_sys_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic [addr_w-1:0]   addr,
   input  logic [word_w-1:0]   data_in,
   input  logic                rd,
   input  logic                wr,
   input  logic                hit_any,
   input  logic                hit_0,
   input  logic                hit_1,
   input  logic                valid_0,
   input  logic                valid_1,
   input  logic                dirty_0,
   input  logic                dirty_1,
   input  logic [tag_w-1:0]    sel_tag,
   input  logic [word_w-1:0]   sel_data,
   input  logic [word_w-1:0]   mem_data,
   input  logic                victim,
   output logic                way_sel,
   output logic                comp_both,
   output logic [tag_w-1:0]    cache_tag,
   output logic [index_w-1:0]  cache_index,
   output logic [offset_w-1:0] cache_offset,
   output logic [word_w-1:0]   cache_wdata,
   output logic                cache_comp,
   output logic                cache_write,
   output logic                cache_valid_in,
   output logic [addr_w-1:0]   mem_addr,
   output logic [word_w-1:0]   mem_wdata,
   output logic                mem_rd,
   output logic                mem_wr,
   output logic [word_w-1:0]   resp_data,
   output logic                resp_load,
   output logic                done,
   output logic                stall,
   output logic                cache_hit,
   output logic                next_victim,
   output logic                err
);

   ctrl_state_t                 state;
   ctrl_state_t                 state_nxt;
   logic [tag_w-1:0]            req_tag;
   logic [index_w-1:0]          req_index;
   logic [offset_w-2:0]         req_word;
   logic [word_w-1:0]           req_data;
   logic                        req_wr;
   logic                        req_err;
   logic                        req_hit;
   logic                        repl_way;
   logic                        pick_way;
   logic                        pick_dirty;
   logic [offset_w-2:0]         cnt;
   logic [offset_w-2:0]         inst_cnt;
   logic [mem_read_latency-1:0] rd_pipe;
   logic                        fill_arrive;

   // Invalid way first, way 0 before way 1, else the victim bit
   assign pick_way    = !valid_0 ? 1'b0 : (!valid_1 ? 1'b1 : victim);
   assign pick_dirty  = pick_way ? dirty_1 : dirty_0;
   assign fill_arrive = rd_pipe[mem_read_latency-1];

   assign done        = (state == st_done) | (state == st_err_done);
   assign err         = (state == st_err_done);
   assign stall       = (state != st_idle);
   assign cache_hit   = (state == st_done) & req_hit;
   assign next_victim = done ? ~victim : victim;
   assign mem_wdata   = sel_data;

   always_ff @(posedge clk) begin
      if (state == st_idle && (rd || wr)) begin
         req_tag   <= addr[addr_w-1:addr_w-tag_w];
         req_index <= addr[offset_w+index_w-1:offset_w];
         req_word  <= addr[offset_w-1:1];
         req_data  <= data_in;
         req_wr    <= wr;
         req_err   <= addr[0] | (rd & wr);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= st_idle;
         cnt      <= '0;
         inst_cnt <= '0;
         rd_pipe  <= '0;
         req_hit  <= 1'b0;
         repl_way <= 1'b0;
      end else begin
         state   <= state_nxt;
         rd_pipe <= {rd_pipe[mem_read_latency-2:0], mem_rd};
         if (state == st_wb_write || state == st_fill_read) begin
            cnt <= cnt + 1'b1;
         end else begin
            cnt <= '0;
         end
         if (fill_arrive) begin
            inst_cnt <= inst_cnt + 1'b1;
         end else if (state == st_idle) begin
            inst_cnt <= '0;
         end
         if (state == st_compare) begin
            req_hit  <= hit_any & ~req_err;
            repl_way <= pick_way;
         end
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (rd || wr) begin
               state_nxt = st_compare;
            end
         end
         st_compare: begin
            if (req_err) begin
               state_nxt = st_err_done;
            end else if (hit_any) begin
               state_nxt = st_done;
            end else if (pick_dirty) begin
               state_nxt = st_wb_write;
            end else begin
               state_nxt = st_fill_read;
            end
         end
         st_wb_write: begin
            if (cnt == '1) begin
               state_nxt = st_wb_wait;
            end
         end
         st_wb_wait: state_nxt = st_fill_read;
         st_fill_read: begin
            if (cnt == '1) begin
               state_nxt = st_fill_wait;
            end
         end
         st_fill_wait: begin
            // Leave once the last refill word is written
            if (fill_arrive && inst_cnt == '1) begin
               state_nxt = st_fill_install;
            end
         end
         st_fill_install: state_nxt = st_done;
         default: state_nxt = st_idle;
      endcase
   end

   always_comb begin
      way_sel        = repl_way;
      comp_both      = 1'b0;
      cache_tag      = req_tag;
      cache_index    = req_index;
      cache_offset   = {req_word, 1'b0};
      cache_wdata    = req_data;
      cache_comp     = 1'b0;
      cache_write    = 1'b0;
      cache_valid_in = 1'b0;
      mem_addr       = {req_tag, req_index, cnt, 1'b0};
      mem_rd         = 1'b0;
      mem_wr         = 1'b0;
      resp_data      = req_wr ? req_data : sel_data;
      resp_load      = 1'b0;
      // Refill words land as they come back, even while reads are issued
      if (fill_arrive) begin
         cache_offset   = {inst_cnt, 1'b0};
         cache_wdata    = mem_data;
         cache_write    = 1'b1;
         cache_valid_in = 1'b1;
      end
      case (state)
         st_compare: begin
            way_sel     = hit_0 ? 1'b0 : hit_1;
            comp_both   = 1'b1;
            cache_comp  = ~req_err;
            cache_write = req_wr & ~req_err;
            resp_load   = hit_any & ~req_err;
         end
         st_wb_write: begin
            cache_offset = {cnt, 1'b0};
            mem_addr     = {sel_tag, req_index, cnt, 1'b0};
            mem_wr       = 1'b1;
         end
         st_fill_read: mem_rd = 1'b1;
         st_fill_install: begin
            cache_comp  = 1'b1;
            cache_write = req_wr;
            resp_load   = 1'b1;
         end
         default: begin
         end
      endcase
   end

endmodule

/* cache/cache_way.sv */
// One way of the set-associative cache
// Reads are combinational, array writes happen on the clock edge with enable
// Hit is not gated by enable, both ways compare in the same cycle
// Only valid and dirty bits are reset, tags and data come up undefined

`timescale 1ns/1ps

module cache_way
   import mem_sys_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   input  logic                enable,
   input  logic                comp,
   input  logic                write,
   input  logic                valid_in,
   input  logic [tag_w-1:0]    tag_in,
   input  logic [index_w-1:0]  index,
   input  logic [offset_w-1:0] offset,
   input  logic [word_w-1:0]   data_in,
   output logic                hit,
   output logic                valid,
   output logic                dirty,
   output logic [tag_w-1:0]    tag_out,
   output logic [word_w-1:0]   data_out
);

   logic [tag_w-1:0]     tag_q [num_lines];
   logic [word_w-1:0]    data_q [num_lines][words_per_line];
   logic [num_lines-1:0] valid_q;
   logic [num_lines-1:0] dirty_q;
   logic [offset_w-2:0]  word;

   // Byte select bit is dropped
   assign word = offset[offset_w-1:1];

   assign valid    = valid_q[index];
   assign dirty    = valid_q[index] & dirty_q[index];
   assign tag_out  = tag_q[index];
   assign data_out = data_q[index][word];
   assign hit      = comp & valid_q[index] & (tag_q[index] == tag_in);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (enable && write) begin
         if (comp) begin
            // Write hit marks the line modified
            if (hit) begin
               dirty_q[index] <= 1'b1;
            end
         end else begin
            valid_q[index] <= valid_in;
            dirty_q[index] <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (enable && write && (hit || !comp)) begin
         data_q[index][word] <= data_in;
         // Install path also sets the tag
         if (!comp) begin
            tag_q[index] <= tag_in;
         end
      end
   end

endmodule

/* common/mem_sys_pkg.sv */
// Shared constants and controller state type for the two-way data cache
// Geometry is fixed: 16-bit byte addresses, 16-bit words, four words a line
// Offset bit 0 is the byte select and must be zero for any legal access
// Memory banks are selected by the word offset, so one line spans all banks

package mem_sys_pkg;

   // Address fields
   localparam int tag_w    = 5;
   localparam int index_w  = 8;
   localparam int offset_w = 3;
   localparam int word_w   = 16;
   localparam int addr_w   = 16;

   // Cache and memory geometry
   localparam int num_lines        = 256;
   localparam int words_per_line   = 4;
   localparam int num_banks        = 4;
   localparam int bank_busy_cycles = 4;
   localparam int mem_read_latency = 2;

   // Controller states
   typedef enum logic [3:0] {
      st_idle,
      st_compare,
      st_wb_write,
      st_wb_wait,
      st_fill_read,
      st_fill_wait,
      st_fill_install,
      st_done,
      st_err_done
   } ctrl_state_t;

endpackage

/* memory/four_bank_mem.sv */
// Four-bank interleaved word memory, bank chosen by address bits 2 to 1
// Read data shows up 2 cycles after rd, writes complete on the clock edge
// A bank stays busy for bank_busy_cycles cycles after any access
// err flags an access to a busy bank or an odd byte address
// Contents start at zero like a simulation model, there is no reset of data

`timescale 1ns/1ps

module four_bank_mem
   import mem_sys_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic [addr_w-1:0] addr,
   input  logic [word_w-1:0] data_in,
   input  logic              rd,
   input  logic              wr,
   output logic [word_w-1:0] data_out,
   output logic              stall,
   output logic              err
);

   typedef logic [$clog2(bank_busy_cycles)-1:0] busy_t;

   logic [word_w-1:0]          mem_q [num_banks][2**(addr_w-offset_w)];
   busy_t                      busy_cnt [num_banks];
   logic [offset_w-2:0]        bank;
   logic [addr_w-offset_w-1:0] row;
   logic                       bank_busy;
   logic [word_w-1:0]          rd_stage1;
   logic [word_w-1:0]          rd_stage2;

   assign bank = addr[offset_w-1:1];
   assign row  = addr[addr_w-1:offset_w];

   assign bank_busy = (busy_cnt[bank] != '0);
   assign stall     = bank_busy;
   assign err       = (rd | wr) & (bank_busy | addr[0]);
   assign data_out  = rd_stage2;

   initial begin
      for (int b = 0; b < num_banks; b++) begin
         for (int r = 0; r < 2**(addr_w-offset_w); r++) begin
            mem_q[b][r] = '0;
         end
      end
   end

   // Per-bank occupancy counters
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int b = 0; b < num_banks; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < num_banks; b++) begin
            if ((rd || wr) && (bank == b)) begin
               busy_cnt[b] <= busy_t'(bank_busy_cycles - 1);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   always @(posedge clk) begin
      if (wr) begin
         mem_q[bank][row] <= data_in;
      end
   end

   // Two-stage read pipeline, a new read may start every cycle
   always_ff @(posedge clk) begin
      if (rd) begin
         rd_stage1 <= mem_q[bank][row];
      end
      rd_stage2 <= rd_stage1;
   end

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the cache testbench with Verilator
# Pass or fail is taken from the simulation log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mem_system_tb \
   -f build.f -o mem_system_sim > build.log 2>&1 \
   && ./obj_dir/mem_system_sim > sim.log 2>&1 \
   || { echo "Build or simulation error"; cat build.log; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^Testbench passed$" sim.log \
   && echo "Simulation PASS" \
   || { echo "Simulation FAIL"; exit 1; }

/* sim/mem_sys_tb_tasks.svh */
// Request and wait tasks plus the shadow memory for the mem_system testbench
// Included inside the testbench module after its signal declarations
// Every task expects to be entered 1 ns after a rising clock edge
// The shadow memory starts at zero like main memory and tracks each completed write

logic [word_w-1:0] shadow_mem [2**(addr_w-1)];

// Outcome of the most recent request
logic [word_w-1:0] last_data;
logic              last_hit;
logic              last_err;
int                last_cycles;

task automatic clear_shadow();
   for (int i = 0; i < 2**(addr_w-1); i++) begin
      shadow_mem[i] = '0;
   end
endtask

function automatic logic [word_w-1:0] expected_word(input logic [addr_w-1:0] a);
   return shadow_mem[a[addr_w-1:1]];
endfunction

task automatic record_write(input logic [addr_w-1:0] a, input logic [word_w-1:0] d);
   shadow_mem[a[addr_w-1:1]] = d;
endtask

// One-cycle rd or wr pulse, issued once the controller is idle
task automatic send_request(input logic is_wr, input logic [addr_w-1:0] a,
                            input logic [word_w-1:0] d);
   while (stall) begin
      @(posedge clk);
      #1;
   end
   addr    = a;
   data_in = d;
   rd      = ~is_wr;
   wr      = is_wr;
   @(posedge clk);
   #1;
   rd = 1'b0;
   wr = 1'b0;
endtask

// Cycles counted from the edge that sampled the request
task automatic wait_done(output int cycles, output logic seen);
   cycles = 1;
   seen   = done;
   while (!seen && cycles < req_timeout) begin
      @(posedge clk);
      #1;
      cycles++;
      seen = done;
   end
endtask

task automatic run_request(input logic is_wr, input logic [addr_w-1:0] a,
                           input logic [word_w-1:0] d);
   logic seen;
   send_request(is_wr, a, d);
   wait_done(last_cycles, seen);
   last_data = data_out;
   last_hit  = cache_hit;
   last_err  = err;
   assert (seen) else begin
      err_count++;
      $display("No done within %0d cycles for request at addr %h", req_timeout, a);
   end
endtask

/* sim/mem_system_tb.sv */
// Testbench for the two-way data cache with four-bank memory
// Inputs change 1 ns after the rising edge, outputs are sampled at that point too
// Expected read data comes from a shadow memory, not from the DUT
// Hit status is only checked where the access history makes it certain

`timescale 1ns/1ps

module mem_system_tb
   import mem_sys_pkg::*;
;

   localparam int clk_period      = 10;
   localparam int reset_cycles    = 5;
   localparam int req_timeout     = 60;
   localparam int num_random      = 200;
   localparam int num_requests    = 10 + num_random;
   localparam int watchdog_cycles = reset_cycles + num_requests * req_timeout;

   logic              clk;
   logic              rst_n;
   logic [addr_w-1:0] addr;
   logic [word_w-1:0] data_in;
   logic              rd;
   logic              wr;
   logic [word_w-1:0] data_out;
   logic              done;
   logic              stall;
   logic              cache_hit;
   logic              err;

   int     err_count;
   int     errs_at_start;
   int     tests_passed;
   int     tests_failed;
   integer seed;

   `include "mem_sys_tb_tasks.svh"

   mem_system mem_system_inst (
      .clk (clk), .rst_n (rst_n), .addr (addr), .data_in (data_in), .rd (rd), .wr (wr),
      .data_out (data_out), .done (done), .stall (stall), .cache_hit (cache_hit), .err (err)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(clk_period / 2) clk = ~clk;
      end
   end

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("Watchdog expired after %0d cycles before all tests finished", watchdog_cycles);
      $display("Testbench failed");
      $finish;
   end

   // Protocol rules on done and stall
   done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
      else begin
         err_count++;
         $display("done stayed high for more than one cycle");
      end
   stall_rise: assert property (@(posedge clk) disable iff (!rst_n)
                                (rd || wr) && !stall |=> stall)
      else begin
         err_count++;
         $display("stall did not rise the cycle after a request");
      end
   stall_hold: assert property (@(posedge clk) disable iff (!rst_n) stall && !done |=> stall)
      else begin
         err_count++;
         $display("stall dropped before done");
      end
   hit_with_done: assert property (@(posedge clk) disable iff (!rst_n) cache_hit |-> done)
      else begin
         err_count++;
         $display("cache_hit high outside a done cycle");
      end
   err_with_done: assert property (@(posedge clk) disable iff (!rst_n) err |-> done)
      else begin
         err_count++;
         $display("err high outside a done cycle");
      end

   task automatic report_mismatch(input string sig, input logic [word_w-1:0] exp,
                                  input logic [word_w-1:0] got);
      err_count++;
      $display("Mismatch %s: expected %h got %h", sig, exp, got);
   endtask

   task automatic begin_test();
      errs_at_start = err_count;
   endtask

   task automatic finish_test(input string name);
      if (err_count == errs_at_start) begin
         tests_passed++;
         $display("%s: pass", name);
      end else begin
         tests_failed++;
         $display("%s: FAIL with %0d errors", name, err_count - errs_at_start);
      end
   endtask

   // Aligned access checked against the shadow memory
   task automatic checked_access(input logic is_wr, input logic [addr_w-1:0] a,
                                 input logic [word_w-1:0] d);
      logic [word_w-1:0] exp;
      exp = is_wr ? d : expected_word(a);
      run_request(is_wr, a, d);
      if (is_wr) begin
         record_write(a, d);
      end
      assert (last_data == exp) else report_mismatch("data_out", exp, last_data);
      assert (!last_err) else report_mismatch("err", 16'h0, {15'h0, last_err});
   endtask

   initial begin
      logic [31:0]       r;
      logic [addr_w-1:0] a;
      rst_n        = 1'b0;
      addr         = '0;
      data_in      = '0;
      rd           = 1'b0;
      wr           = 1'b0;
      err_count    = 0;
      tests_passed = 0;
      tests_failed = 0;
      seed         = 32'h85e2_7a82;
      clear_shadow();
      repeat (reset_cycles) @(posedge clk);
      #1;
      rst_n = 1'b1;

      begin_test();
      @(posedge clk);
      #1;
      assert (!done) else report_mismatch("done", 16'h0, {15'h0, done});
      assert (!stall) else report_mismatch("stall", 16'h0, {15'h0, stall});
      assert (!err) else report_mismatch("err", 16'h0, {15'h0, err});
      finish_test("reset");

      begin_test();
      checked_access(1'b1, 16'h2a46, 16'hbeef);
      assert (!last_hit) else report_mismatch("cache_hit", 16'h0, {15'h0, last_hit});
      checked_access(1'b0, 16'h2a46, 16'h0000);
      finish_test("write_read");

      begin_test();
      checked_access(1'b0, 16'h2a46, 16'h0000);
      assert (last_hit) else report_mismatch("cache_hit", 16'h1, {15'h0, last_hit});
      assert (last_cycles == 2) else begin
         err_count++;
         $display("Hit completed after %0d cycles instead of 2", last_cycles);
      end
      finish_test("hit_latency");

      // Three tags on one index, the third write evicts a dirty line
      begin_test();
      for (int i = 0; i < 3; i++) begin
         a = {5'(3 + 4 * i), 8'h5d, 3'b010};
         checked_access(1'b1, a, 16'hd100 | 16'(i));
      end
      assert (!last_hit) else report_mismatch("cache_hit", 16'h0, {15'h0, last_hit});
      for (int i = 0; i < 3; i++) begin
         a = {5'(3 + 4 * i), 8'h5d, 3'b010};
         checked_access(1'b0, a, 16'h0000);
      end
      finish_test("write_back");

      begin_test();
      for (int n = 0; n < num_random; n++) begin
         r = $random(seed);
         a = {3'b000, r[1:0], 6'b000000, r[3:2], r[5:4], 1'b0};
         checked_access(r[6], a, r[31:16]);
      end
      finish_test("random_mix");

      begin_test();
      run_request(1'b0, 16'h2a47, 16'h0000);
      assert (last_err) else report_mismatch("err", 16'h1, {15'h0, last_err});
      assert (!last_hit) else report_mismatch("cache_hit", 16'h0, {15'h0, last_hit});
      finish_test("misaligned");

      $display("Tests: %0d passed, %0d failed, %0d check errors",
               tests_passed, tests_failed, err_count);
      if (tests_failed == 0 && err_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

/* source/mem_system.sv */
// Two-way write-back, write-allocate data cache over a four-bank memory
// One request at a time, rd and wr are one-cycle pulses taken while stall is low
// Hits complete 2 cycles after the request, misses take longer
// data_out holds the last response until the next done

`timescale 1ns/1ps

module mem_system
   import mem_sys_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic [addr_w-1:0] addr,
   input  logic [word_w-1:0] data_in,
   input  logic              rd,
   input  logic              wr,
   output logic [word_w-1:0] data_out,
   output logic              done,
   output logic              stall,
   output logic              cache_hit,
   output logic              err
);

   logic                hit_0, hit_1, hit_any;
   logic                valid_0, valid_1;
   logic                dirty_0, dirty_1;
   logic [tag_w-1:0]    tag_0, tag_1, sel_tag;
   logic [word_w-1:0]   data_0, data_1, sel_data;
   logic                way_sel, comp_both;
   logic                en_0, en_1;
   logic [tag_w-1:0]    cache_tag;
   logic [index_w-1:0]  cache_index;
   logic [offset_w-1:0] cache_offset;
   logic [word_w-1:0]   cache_wdata;
   logic                cache_comp, cache_write, cache_valid_in;
   logic [addr_w-1:0]   mem_addr;
   logic [word_w-1:0]   mem_wdata, mem_data;
   logic                mem_rd, mem_wr, mem_err;
   logic [word_w-1:0]   resp_data, resp_q;
   logic                resp_load;
   logic                victim_q, next_victim;
   logic                ctrl_err;

   assign en_0     = comp_both | ~way_sel;
   assign en_1     = comp_both | way_sel;
   assign hit_any  = hit_0 | hit_1;
   assign sel_tag  = way_sel ? tag_1 : tag_0;
   assign sel_data = way_sel ? data_1 : data_0;
   // Request errors come from the controller, bank conflicts from memory
   assign err      = ctrl_err | mem_err;
   assign data_out = resp_q;

   cache_way way0_inst (
      .clk (clk), .rst_n (rst_n), .enable (en_0),
      .comp (cache_comp), .write (cache_write), .valid_in (cache_valid_in),
      .tag_in (cache_tag), .index (cache_index), .offset (cache_offset),
      .data_in (cache_wdata), .hit (hit_0), .valid (valid_0), .dirty (dirty_0),
      .tag_out (tag_0), .data_out (data_0)
   );

   cache_way way1_inst (
      .clk (clk), .rst_n (rst_n), .enable (en_1),
      .comp (cache_comp), .write (cache_write), .valid_in (cache_valid_in),
      .tag_in (cache_tag), .index (cache_index), .offset (cache_offset),
      .data_in (cache_wdata), .hit (hit_1), .valid (valid_1), .dirty (dirty_1),
      .tag_out (tag_1), .data_out (data_1)
   );

   // Controller schedules by cycle count, bank stall is left open
   four_bank_mem mem_inst (
      .clk (clk), .rst_n (rst_n), .addr (mem_addr), .data_in (mem_wdata),
      .rd (mem_rd), .wr (mem_wr), .data_out (mem_data), .stall (), .err (mem_err)
   );

   cache_ctrl ctrl_inst (
      .clk (clk), .rst_n (rst_n), .addr (addr), .data_in (data_in),
      .rd (rd), .wr (wr), .hit_any (hit_any), .hit_0 (hit_0), .hit_1 (hit_1),
      .valid_0 (valid_0), .valid_1 (valid_1), .dirty_0 (dirty_0), .dirty_1 (dirty_1),
      .sel_tag (sel_tag), .sel_data (sel_data), .mem_data (mem_data),
      .victim (victim_q), .way_sel (way_sel), .comp_both (comp_both),
      .cache_tag (cache_tag), .cache_index (cache_index), .cache_offset (cache_offset),
      .cache_wdata (cache_wdata), .cache_comp (cache_comp), .cache_write (cache_write),
      .cache_valid_in (cache_valid_in), .mem_addr (mem_addr), .mem_wdata (mem_wdata),
      .mem_rd (mem_rd), .mem_wr (mem_wr), .resp_data (resp_data),
      .resp_load (resp_load), .done (done), .stall (stall), .cache_hit (cache_hit),
      .next_victim (next_victim), .err (ctrl_err)
   );

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         victim_q <= 1'b0;
      end else begin
         victim_q <= next_victim;
      end
   end

   always_ff @(posedge clk) begin
      if (resp_load) begin
         resp_q <= resp_data;
      end
   end

endmodule
